// ==== source/rs5_pkg.sv ====
////////////////////
// Shared widths, opcodes and encodings for the reduced RV32I core
// Only OP, OP-IMM, LUI and SW are decoded, everything else retires as a bubble
////////////////////
package rs5_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // Register values, results, store data
    typedef logic [XLEN-1:0] addr_t;      // Byte address
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    localparam addr_t RESET_PC = '0;      // First fetch

    ////////////////////
    // Opcodes
    ////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU operation chosen in decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                        // LUI, operand b straight through
    } alu_op_e;

    // Effect at retire
    typedef enum logic [1:0] {
        KIND_NONE,                        // Bubble or unknown opcode
        KIND_WRITE_REG,
        KIND_STORE
    } ex_kind_e;

endpackage

// ==== source/fetch.sv ====
////////////////////
// No jumps, PC only moves forward by four
// Instruction memory must answer in the same cycle
////////////////////
`timescale 1ns/10ps

module fetch
    import rs5_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   enable_i,
    input  instr_t instruction_i,
    output addr_t  instruction_address_o,
    output instr_t instruction_o,
    output addr_t  pc_o,
    output logic   valid_o
);

    addr_t pc;

    assign instruction_address_o = pc;    // Memory sees PC directly

    // PC and valid bit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc      <= RESET_PC;
            valid_o <= 1'b0;
        end else if (enable_i) begin
            pc      <= pc + addr_t'(4);
            valid_o <= 1'b1;              // Every fetched word is real
        end
    end

    // Word and its address for decode
    always_ff @(posedge clk) begin
        if (enable_i) begin
            instruction_o <= instruction_i;
            pc_o          <= pc;
        end
    end

    // Alignment must survive any stall pattern
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc[1:0] == 2'b00);

endmodule

// ==== source/decode.sv ====
////////////////////
// Operands are forwarded from execute, then retire, then the register file
// SW is sent to the ALU as base plus offset
////////////////////
`timescale 1ns/10ps

module decode
    import rs5_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     enable_i,
    input  instr_t   instruction_i,
    input  addr_t    pc_i,
    input  logic     valid_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  reg_idx_t exe_rd_i,
    input  logic     exe_write_i,
    input  word_t    exe_result_i,
    input  reg_idx_t ret_rd_i,
    input  logic     ret_write_i,
    input  word_t    ret_data_i,
    output alu_op_e  alu_op_o,
    output word_t    operand_a_o,
    output word_t    operand_b_o,
    output word_t    store_data_o,
    output reg_idx_t rd_o,
    output ex_kind_e kind_o,
    output logic     valid_o
);

    ////////////////////
    // Fields
    ////////////////////

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;                // SUB and SRA select
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    alu_op_e    alu_op;
    word_t      operand_b;
    ex_kind_e   kind;

    assign opcode    = instruction_i[6:0];
    assign rd        = instruction_i[11:7];
    assign funct3    = instruction_i[14:12];
    assign rs1_o     = instruction_i[19:15];
    assign rs2_o     = instruction_i[24:20];
    assign funct7_b5 = instruction_i[30];

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_u = {instruction_i[31:12], 12'b0};

    // Newest producer wins
    function automatic word_t forward(input reg_idx_t idx, input word_t rf_data);
        if (idx == '0)
            return '0;                    // x0
        else if (exe_write_i && exe_rd_i == idx)
            return exe_result_i;          // One ahead
        else if (ret_write_i && ret_rd_i == idx)
            return ret_data_i;            // Two ahead, write lands this edge
        else
            return rf_data;
    endfunction

    always_comb begin
        rs1_fwd = forward(rs1_o, rs1_data_i);
        rs2_fwd = forward(rs2_o, rs2_data_i);
    end

    ////////////////////
    // Decoder
    ////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        operand_b = imm_i;
        kind      = KIND_NONE;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000: begin
                        if (opcode == OPC_OP && funct7_b5)
                            alu_op = ALU_SUB;     // No SUBI
                    end
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: begin
                        if (funct7_b5)
                            alu_op = ALU_SRA;
                        else
                            alu_op = ALU_SRL;
                    end
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                if (opcode == OPC_OP)
                    operand_b = rs2_fwd;
                kind = KIND_WRITE_REG;
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                operand_b = imm_u;
                kind      = KIND_WRITE_REG;
            end
            OPC_STORE: begin
                operand_b = imm_s;                // Address = rs1 + offset
                if (funct3 == 3'b010)
                    kind = KIND_STORE;            // SW only
            end
            default: ;                            // Bubble
        endcase
        if (kind == KIND_WRITE_REG && rd == '0)
            kind = KIND_NONE;                     // Writes to x0 dropped here
    end

    ////////////////////
    // Decode to execute
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else if (enable_i)
            valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            alu_op_o     <= alu_op;
            operand_a_o  <= rs1_fwd;
            operand_b_o  <= operand_b;
            store_data_o <= rs2_fwd;
            rd_o         <= rd;
            kind_o       <= kind;
        end
    end

    // Execute forwarding relies on this
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o && kind_o == KIND_WRITE_REG |-> rd_o != '0);

    // Straight-line flow, consecutive accepted words are 4 apart
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(enable_i && valid_i) |-> pc_i == $past(pc_i) + addr_t'(4));

endmodule

// ==== source/regbank.sv ====
////////////////////
// Flip-flop register file, x1 to x31, write lands on the clock edge
////////////////////
`timescale 1ns/10ps

module regbank
    import rs5_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     write_i,
    input  word_t    data_i,
    output word_t    data1_o,
    output word_t    data2_o
);

    word_t regs [1:31];                   // No storage for x0

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (write_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Combinational reads, x0 is zero
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== source/execute.sv ====
////////////////////
// Single-cycle ALU, shifts use the low five bits of operand b
////////////////////
`timescale 1ns/10ps

module execute
    import rs5_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     enable_i,
    input  alu_op_e  alu_op_i,
    input  word_t    operand_a_i,
    input  word_t    operand_b_i,
    input  word_t    store_data_i,
    input  reg_idx_t rd_i,
    input  ex_kind_e kind_i,
    input  logic     valid_i,
    output word_t    result_fwd_o,
    output reg_idx_t rd_fwd_o,
    output logic     write_fwd_o,
    output word_t    result_o,
    output reg_idx_t rd_o,
    output ex_kind_e kind_o,
    output word_t    store_data_o,
    output logic     valid_o
);

    word_t      alu_result;
    logic [4:0] shamt;

    assign shamt = operand_b_i[4:0];

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result = operand_a_i + operand_b_i;
            ALU_SUB:    alu_result = operand_a_i - operand_b_i;
            ALU_SLL:    alu_result = operand_a_i << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}},
                                      $signed(operand_a_i) < $signed(operand_b_i)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, operand_a_i < operand_b_i};
            ALU_XOR:    alu_result = operand_a_i ^ operand_b_i;
            ALU_SRL:    alu_result = operand_a_i >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(operand_a_i) >>> shamt);
            ALU_OR:     alu_result = operand_a_i | operand_b_i;
            ALU_AND:    alu_result = operand_a_i & operand_b_i;
            ALU_PASS_B: alu_result = operand_b_i;        // LUI
            default:    alu_result = '0;
        endcase
    end

    // Back to decode, same cycle
    assign result_fwd_o = alu_result;
    assign rd_fwd_o     = rd_i;
    assign write_fwd_o  = valid_i && kind_i == KIND_WRITE_REG;

    ////////////////////
    // Execute to retire
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else if (enable_i)
            valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            result_o     <= alu_result;   // Store address for SW
            rd_o         <= rd_i;
            kind_o       <= kind_i;
            store_data_o <= store_data_i;
        end
    end

    // Decode must hand over a defined kind with every valid slot
    a_kind_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i |-> !$isunknown(kind_i));

endmodule

// ==== source/retire.sv ====
////////////////////
// Register write is combinational, data port is registered and full-word only
////////////////////
`timescale 1ns/10ps

module retire
    import rs5_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       enable_i,
    input  word_t      result_i,
    input  reg_idx_t   rd_i,
    input  ex_kind_e   kind_i,
    input  word_t      store_data_i,
    input  logic       valid_i,
    output logic       reg_write_o,
    output reg_idx_t   reg_rd_o,
    output word_t      reg_data_o,
    output logic [3:0] mem_write_enable_o,
    output addr_t      mem_address_o,
    output word_t      mem_data_o
);

    // Also the retire forwarding path
    assign reg_write_o = valid_i && kind_i == KIND_WRITE_REG;
    assign reg_rd_o    = rd_i;
    assign reg_data_o  = result_i;

    // Data port, held while stalled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_write_enable_o <= '0;
            mem_address_o      <= '0;
            mem_data_o         <= '0;
        end else if (enable_i) begin
            if (valid_i && kind_i == KIND_STORE) begin
                mem_write_enable_o <= '1;                 // SW, all lanes
                mem_address_o      <= addr_t'(result_i);
                mem_data_o         <= store_data_i;
            end else begin
                mem_write_enable_o <= '0;
                mem_address_o      <= '0;
                mem_data_o         <= '0;
            end
        end
    end

endmodule

// ==== source/rs5_core.sv ====
////////////////////
// Four-stage RV32I slice, stall_i freezes every stage at once
// No hazard stall, all dependencies resolved by forwarding
////////////////////
`timescale 1ns/10ps

module rs5_core
    import rs5_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  instr_t     instruction_i,
    output addr_t      instruction_address_o,
    output logic [3:0] mem_write_enable_o,
    output addr_t      mem_address_o,
    output word_t      mem_data_o
);

    logic     enable;                     // Shared by all stages

    ////////////////////
    // Fetch to decode
    ////////////////////

    instr_t   instruction_decode;
    addr_t    pc_decode;
    logic     valid_decode;

    ////////////////////
    // Register file
    ////////////////////

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    regbank_data1;
    word_t    regbank_data2;

    ////////////////////
    // Decode to execute
    ////////////////////

    alu_op_e  alu_op_execute;
    word_t    operand_a_execute;
    word_t    operand_b_execute;
    word_t    store_data_execute;
    reg_idx_t rd_execute;
    ex_kind_e kind_execute;
    logic     valid_execute;
    word_t    result_fwd;                 // Execute bypass
    reg_idx_t rd_fwd;
    logic     write_fwd;

    ////////////////////
    // Execute to retire
    ////////////////////

    word_t    result_retire;
    reg_idx_t rd_retire;
    ex_kind_e kind_retire;
    word_t    store_data_retire;
    logic     valid_retire;
    logic     reg_write;                  // Writeback, also retire bypass
    reg_idx_t reg_rd;
    word_t    reg_data;

    assign enable = !stall_i;

    fetch fetch1 (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .enable_i              (enable),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .instruction_o         (instruction_decode),
        .pc_o                  (pc_decode),
        .valid_o               (valid_decode)
    );

    decode decoder1 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable),
        .instruction_i (instruction_decode),
        .pc_i          (pc_decode),
        .valid_i       (valid_decode),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (regbank_data1),
        .rs2_data_i    (regbank_data2),
        .exe_rd_i      (rd_fwd),
        .exe_write_i   (write_fwd),
        .exe_result_i  (result_fwd),
        .ret_rd_i      (reg_rd),
        .ret_write_i   (reg_write),
        .ret_data_i    (reg_data),
        .alu_op_o      (alu_op_execute),
        .operand_a_o   (operand_a_execute),
        .operand_b_o   (operand_b_execute),
        .store_data_o  (store_data_execute),
        .rd_o          (rd_execute),
        .kind_o        (kind_execute),
        .valid_o       (valid_execute)
    );

    regbank regbankff (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (reg_rd),
        .write_i (reg_write),
        .data_i  (reg_data),
        .data1_o (regbank_data1),
        .data2_o (regbank_data2)
    );

    execute execute1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .enable_i     (enable),
        .alu_op_i     (alu_op_execute),
        .operand_a_i  (operand_a_execute),
        .operand_b_i  (operand_b_execute),
        .store_data_i (store_data_execute),
        .rd_i         (rd_execute),
        .kind_i       (kind_execute),
        .valid_i      (valid_execute),
        .result_fwd_o (result_fwd),
        .rd_fwd_o     (rd_fwd),
        .write_fwd_o  (write_fwd),
        .result_o     (result_retire),
        .rd_o         (rd_retire),
        .kind_o       (kind_retire),
        .store_data_o (store_data_retire),
        .valid_o      (valid_retire)
    );

    retire retire1 (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .enable_i           (enable),
        .result_i           (result_retire),
        .rd_i               (rd_retire),
        .kind_i             (kind_retire),
        .store_data_i       (store_data_retire),
        .valid_i            (valid_retire),
        .reg_write_o        (reg_write),
        .reg_rd_o           (reg_rd),
        .reg_data_o         (reg_data),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_address_o      (mem_address_o),
        .mem_data_o         (mem_data_o)
    );

endmodule

// ==== tests/tb_rs5_model.svh ====
////////////////////
// Reference ISA model, included inside tb_rs5_core after prog is declared
// Registers come from x0..x6 so most instructions depend on recent results
////////////////////
`ifndef TB_RS5_MODEL_SVH
`define TB_RS5_MODEL_SVH

word_t model_regs [32];                   // Architectural state
addr_t exp_addr [$];                      // Stores in program order
word_t exp_data [$];

// RV32I integer semantics, selected by funct3 and the alternate bit
function automatic word_t isa_result(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void set_model_reg(reg_idx_t rd, word_t value);
    if (rd != 5'd0)
        model_regs[rd] = value;           // x0 stays zero
endfunction

////////////////////
// Program generator
////////////////////

task automatic build_program();
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [19:0] upper;
    logic        alt;
    int unsigned pick;
    foreach (model_regs[r])
        model_regs[r] = '0;
    for (int n = 0; n < PROG_LEN - 2; n++) begin
        rd    = reg_idx_t'($urandom_range(6));
        rs1   = reg_idx_t'($urandom_range(6));
        rs2   = reg_idx_t'($urandom_range(6));
        f3    = 3'($urandom_range(7));
        imm   = 12'($urandom);
        upper = 20'($urandom);
        pick  = $urandom_range(19);
        if (pick < 8) begin                                   // OP
            alt = (f3 == 3'b000 || f3 == 3'b101) && ($urandom_range(1) == 1);
            prog.push_back({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP});
            set_model_reg(rd, isa_result(f3, alt, model_regs[rs1], model_regs[rs2]));
        end else if (pick < 12) begin                         // OP-IMM
            alt = 1'b0;
            if (f3 == 3'b101)
                alt = ($urandom_range(1) == 1);               // SRAI
            if (f3 == 3'b001 || f3 == 3'b101)
                imm = {1'b0, alt, 5'b0, imm[4:0]};            // Shamt in low bits
            prog.push_back({imm, rs1, f3, rd, OPC_OP_IMM});
            set_model_reg(rd, isa_result(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm}));
        end else if (pick < 14) begin                         // LUI
            prog.push_back({upper, rd, OPC_LUI});
            set_model_reg(rd, {upper, 12'b0});
        end else if (pick < 19) begin                         // SW
            prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
            exp_addr.push_back(model_regs[rs1] + {{20{imm[11]}}, imm});
            exp_data.push_back(model_regs[rs2]);
        end else begin
            prog.push_back({25'($urandom), 7'b0001011});      // custom-0, no effect
        end
    end
    // Closing pair, write to x0 then store x0
    prog.push_back({12'h7ff, 5'd1, 3'b000, 5'd0, OPC_OP_IMM});
    prog.push_back({7'd0, 5'd0, 5'd1, 3'b010, 5'd4, OPC_STORE});
    exp_addr.push_back(model_regs[1] + 32'd4);
    exp_data.push_back(32'd0);
endtask

`endif

// ==== tests/tb_rs5_core.sv ====
////////////////////
// Random program against the reference model with random stall_i
// Instruction memory answers combinationally, NOP past the program end
////////////////////
`timescale 1ns/10ps

module tb_rs5_core
    import rs5_pkg::*;
#(
    parameter int unsigned SEED = 32'hea68
);

    localparam int     CLK_PERIOD     = 40;
    localparam int     DRIVE_DELAY    = 2;        // After the rising edge
    localparam int     RESET_CYCLES   = 10;
    localparam int     PROG_LEN       = 128;
    localparam int     TIMEOUT_CYCLES = 4000;
    localparam int     DRAIN_CYCLES   = 20;       // Watch for extra stores
    localparam instr_t NOP            = 32'h0000_0013;

    logic       clk;
    logic       rst_n_i;
    logic       stall_i;
    instr_t     instruction_i;
    addr_t      instruction_address_o;
    logic [3:0] mem_write_enable_o;
    addr_t      mem_address_o;
    word_t      mem_data_o;

    instr_t     prog [$];                         // Instruction memory
    int         cycles;

    `include "tb_rs5_model.svh"

    rs5_core i_rs5_core (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic report_problem(string what);
        $display("%s (time %0t)", what, $time);
        abort_run();
    endtask

    task automatic value_error(string name, word_t expected, word_t actual);
        $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
        abort_run();
    endtask

    function automatic instr_t fetch_word(addr_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size())
            return prog[idx];
        return NOP;
    endfunction

    // Same-cycle instruction memory
    always @(instruction_address_o)
        instruction_i = fetch_word(instruction_address_o);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Checks
    ////////////////////

    a_reset_we: assert property (@(posedge clk) !rst_n_i |-> mem_write_enable_o == 4'b0000)
        else value_error("mem_write_enable_o", 32'h0, 32'($sampled(mem_write_enable_o)));

    a_reset_pc: assert property (@(posedge clk) !rst_n_i |-> instruction_address_o == RESET_PC)
        else value_error("instruction_address_o", RESET_PC, $sampled(instruction_address_o));

    // Frozen PC and data port across a stalled cycle
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(instruction_address_o) && $stable(mem_write_enable_o)
                    && $stable(mem_address_o) && $stable(mem_data_o))
        else report_problem("instruction address or data port moved during a stall");

    // One count per unstalled cycle with a store on the port
    always @(posedge clk) begin
        if (rst_n_i && !stall_i && mem_write_enable_o != 4'b0000) begin
            assert (exp_addr.size() != 0)
                else report_problem("a store appeared after the expected queue was empty");
            assert (mem_write_enable_o == 4'b1111)
                else value_error("mem_write_enable_o", 32'hf, 32'(mem_write_enable_o));
            assert (mem_address_o == exp_addr[0])
                else value_error("mem_address_o", exp_addr[0], mem_address_o);
            assert (mem_data_o == exp_data[0])
                else value_error("mem_data_o", exp_data[0], mem_data_o);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        void'($urandom(SEED));
        rst_n_i       = 1'b1;
        stall_i       = 1'b0;
        instruction_i = NOP;
        build_program();
        instruction_i = fetch_word(instruction_address_o);
        #1;
        rst_n_i = 1'b0;                           // Clean falling edge
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        cycles  = 0;
        while (exp_addr.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            stall_i = ($urandom_range(3) == 0);   // About one stall in four
            cycles++;
        end
        if (exp_addr.size() != 0)
            report_problem("timeout before all expected stores reached the data port");
        stall_i = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+tests
source/rs5_pkg.sv
source/fetch.sv
source/decode.sv
source/regbank.sv
source/execute.sv
source/retire.sv
source/rs5_core.sv
tests/tb_rs5_core.sv

// ==== Makefile ====
# Verilator build of the RV32I slice and its testbench
VERILATOR ?= verilator
TOP       ?= tb_rs5_core
SEED      ?= 60008
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

SOURCES := files.f $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f files.f --Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
